// File: src/Common.sv
`default_nettype none

package Common;

   // Datapath widths
   localparam int DATA_WIDTH = 32;
   localparam int BYTE_WIDTH = 8;
   localparam int HALF_WIDTH = 16;
   localparam int BYTE_LANES = DATA_WIDTH / BYTE_WIDTH;   // 4 lanes per word

   // Byte address, 1 KiB of data memory
   localparam int ADDR_WIDTH = 10;

   // Memory depth in words
   localparam int MEM_WORDS = 256;
   localparam int WORD_IDX_WIDTH = $clog2(MEM_WORDS);    // Matches ADDR_WIDTH - 2

   // Memory opcode seen by the stage
   typedef enum logic [3:0] {
      MEM_NONE = 4'd0,   // No access this cycle
      MEM_LB   = 4'd1,   // Signed byte load
      MEM_LH   = 4'd2,   // Signed half load
      MEM_LW   = 4'd3,   // Word load
      MEM_LBU  = 4'd4,   // Unsigned byte load
      MEM_LHU  = 4'd5,   // Unsigned half load
      MEM_SB   = 4'd6,   // Byte store
      MEM_SH   = 4'd7,   // Half store
      MEM_SW   = 4'd8    // Word store
   } memInstType;

   // Word coming back from memory, also the extracted load result
   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      logic                  done;   // Access completed on the last edge
   } MemResult;

   // Request presented to the data memory
   //
   // Lane data is already replicated across the word,
   // the mask picks which lanes actually get written.
   typedef struct packed {
      logic [WORD_IDX_WIDTH-1:0] wordIdx;   // Word address
      logic [BYTE_LANES-1:0]     mask;      // Byte write enables
      logic                      read;
      logic                      write;
      logic [DATA_WIDTH-1:0]     data;      // Lane data for stores
   } MemRequest;

endpackage

`default_nettype wire

// File: src/ControllerMem.sv
`timescale 1ns/10ps
`default_nettype none

module ControllerMem (
   input  logic [Common::ADDR_WIDTH-1:0] addr,
   input  Common::MemResult              memOut,
   input  Common::memInstType            instType,
   input  logic                          exception,
   output Common::MemResult              dataRead,
   output logic [Common::BYTE_LANES-1:0] maskByte,
   output logic                          read,
   output logic                          write
);

   import Common::*;

   logic [1:0] offset;   // Byte position inside the word

   assign offset = addr[1:0];

   always_comb begin
      dataRead.data = '0;
      dataRead.done = memOut.done;   // Done is not touched here
      maskByte      = '0;
      read          = 1'b0;
      write         = 1'b0;

      case (instType)
         MEM_LB: begin
            read = 1'b1;
            unique case (offset)
               2'd0: dataRead.data = DATA_WIDTH'($signed(memOut.data[7:0]));
               2'd1: dataRead.data = DATA_WIDTH'($signed(memOut.data[15:8]));
               2'd2: dataRead.data = DATA_WIDTH'($signed(memOut.data[23:16]));
               2'd3: dataRead.data = DATA_WIDTH'($signed(memOut.data[31:24]));
            endcase
         end

         MEM_LBU: begin
            read = 1'b1;
            unique case (offset)
               2'd0: dataRead.data = DATA_WIDTH'(memOut.data[7:0]);
               2'd1: dataRead.data = DATA_WIDTH'(memOut.data[15:8]);
               2'd2: dataRead.data = DATA_WIDTH'(memOut.data[23:16]);
               2'd3: dataRead.data = DATA_WIDTH'(memOut.data[31:24]);
            endcase
         end

         MEM_LH: begin
            read = 1'b1;
            unique case (offset)
               2'd0: dataRead.data = DATA_WIDTH'($signed(memOut.data[15:0]));
               2'd1: dataRead.data = DATA_WIDTH'($signed(memOut.data[23:8]));
               2'd2: dataRead.data = DATA_WIDTH'($signed(memOut.data[31:16]));
               2'd3: dataRead.data = '0;   // Half would cross the word
            endcase
         end

         MEM_LHU: begin
            read = 1'b1;
            unique case (offset)
               2'd0: dataRead.data = DATA_WIDTH'(memOut.data[15:0]);
               2'd1: dataRead.data = DATA_WIDTH'(memOut.data[23:8]);
               2'd2: dataRead.data = DATA_WIDTH'(memOut.data[31:16]);
               2'd3: dataRead.data = '0;
            endcase
         end

         MEM_LW: begin
            read          = 1'b1;
            dataRead.data = memOut.data;   // Offset ignored for words
         end

         MEM_SB: begin
            write = 1'b1;
            unique case (offset)
               2'd0: maskByte = 4'b0001;
               2'd1: maskByte = 4'b0010;
               2'd2: maskByte = 4'b0100;
               2'd3: maskByte = 4'b1000;
            endcase
         end

         MEM_SH: begin
            write = 1'b1;
            unique case (offset)
               2'd0: maskByte = 4'b0011;
               2'd1: maskByte = 4'b0110;
               2'd2: maskByte = 4'b1100;
               2'd3: maskByte = 4'b0000;   // Crosses the word, nothing written
            endcase
         end

         MEM_SW: begin
            write = 1'b1;
            // Only aligned words reach the array
            if (offset == 2'd0) begin
               maskByte = 4'b1111;
            end else begin
               maskByte = 4'b0000;
            end
         end

         default: begin
            read  = 1'b0;
            write = 1'b0;
         end
      endcase

      // Trap from elsewhere in the core, loads still go ahead
      if (exception) begin
         write = 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: src/StoreAligner.sv
`timescale 1ns/10ps
`default_nettype none

module StoreAligner (
   input  Common::memInstType            instType,
   input  logic [Common::DATA_WIDTH-1:0] storeData,
   output logic [Common::DATA_WIDTH-1:0] laneData
);

   import Common::*;

   // Store data is copied onto every lane it could land in.
   // ControllerMem's mask then decides which lanes are written,
   // so no address is needed here.
   always_comb begin
      case (instType)
         MEM_SB: begin
            laneData = {BYTE_LANES{storeData[BYTE_WIDTH-1:0]}};   // b b b b
         end

         MEM_SH: begin
            laneData = {(DATA_WIDTH / HALF_WIDTH){storeData[HALF_WIDTH-1:0]}};   // h h
         end

         default: begin
            laneData = storeData;   // SW and non-stores
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/DataMemory.sv
`timescale 1ns/10ps
`default_nettype none

module DataMemory (
   input  logic              clk,
   input  logic              rstN,
   input  Common::MemRequest req,
   output Common::MemResult  memOut
);

   import Common::*;

   logic [DATA_WIDTH-1:0] mem [MEM_WORDS];   // Word array, contents survive reset

   // Byte-enabled write
   always_ff @(posedge clk) begin
      if (req.write) begin
         for (int i = 0; i < BYTE_LANES; i++) begin
            if (req.mask[i]) begin
               mem[req.wordIdx][i*BYTE_WIDTH +: BYTE_WIDTH] <=
                  req.data[i*BYTE_WIDTH +: BYTE_WIDTH];
            end
         end
      end
   end

   // Registered read word and done
   always_ff @(posedge clk) begin
      if (!rstN) begin
         memOut.data <= '0;
         memOut.done <= 1'b0;
      end else begin
         if (req.read) begin
            memOut.data <= mem[req.wordIdx];
         end
         memOut.done <= req.read | req.write;   // One cycle after any access
      end
   end

endmodule

`default_nettype wire

// File: src/MemStage.sv
`timescale 1ns/10ps
`default_nettype none

module MemStage (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic [Common::ADDR_WIDTH-1:0] addr,
   input  Common::memInstType            instType,
   input  logic [Common::DATA_WIDTH-1:0] storeData,
   input  logic                          exception,
   output Common::MemResult              loadResult,
   output logic                          busy
);

   import Common::*;

   logic [BYTE_LANES-1:0] maskByte;
   logic                  read;
   logic                  write;
   logic [DATA_WIDTH-1:0] laneData;
   MemRequest             memReq;
   MemResult              memOut;   // Raw registered word

   ControllerMem uController (
      .addr      (addr),
      .memOut    (memOut),
      .instType  (instType),
      .exception (exception),
      .dataRead  (loadResult),
      .maskByte  (maskByte),
      .read      (read),
      .write     (write)
   );

   StoreAligner uAligner (
      .instType  (instType),
      .storeData (storeData),
      .laneData  (laneData)
   );

   // Word index drops the byte offset
   assign memReq.wordIdx = addr[ADDR_WIDTH-1:2];
   assign memReq.mask    = maskByte;
   assign memReq.read    = read;
   assign memReq.write   = write;
   assign memReq.data    = laneData;

   DataMemory uMemory (
      .clk    (clk),
      .rstN   (rstN),
      .req    (memReq),
      .memOut (memOut)
   );

   assign busy = read | write;   // Access issued this cycle

endmodule

`default_nettype wire

// File: tb/ClockGen.sv
`timescale 1ns/10ps
`default_nettype none

module ClockGen (
   output logic clk,
   output logic rstN
);

   localparam int HALF_PERIOD  = 50;   // 100 ns clock
   localparam int RESET_CYCLES = 16;

   initial begin
      clk = 1'b0;
      forever #HALF_PERIOD clk = ~clk;
   end

   // Reset released on a rising edge, like any other synchronous input
   initial begin
      rstN = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rstN <= 1'b1;
   end

endmodule

`default_nettype wire

// File: tb/MemStageChecker.sv
`timescale 1ns/10ps
`default_nettype none

module MemStageChecker (
   input  logic                          clk,
   input  logic                          rstN,
   input  logic [Common::ADDR_WIDTH-1:0] addr,
   input  Common::memInstType            instType,
   input  logic [Common::DATA_WIDTH-1:0] storeData,
   input  logic                          exception,
   input  Common::MemResult              loadResult,
   input  logic                          busy,
   output int                            errorCount,
   output int                            loadChecks
);

   import Common::*;

   localparam int MODEL_BYTES = 64;   // First 16 words only

   // Inputs seen during one cycle
   typedef struct packed {
      logic                  valid;
      logic                  rstN;
      memInstType            op;
      logic [ADDR_WIDTH-1:0] addr;
      logic [DATA_WIDTH-1:0] data;
      logic                  exc;
   } AccessSample;

   logic [7:0]  model [MODEL_BYTES];
   AccessSample prev = '0;
   int          errCount = 0;
   int          loadCount = 0;

   assign errorCount = errCount;
   assign loadChecks = loadCount;

   function automatic logic isLoad(memInstType op);
      return op inside {MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
   endfunction

   function automatic logic isStore(memInstType op);
      return op inside {MEM_SB, MEM_SH, MEM_SW};
   endfunction

   function automatic logic [31:0] expectedLoad(memInstType op, logic [ADDR_WIDTH-1:0] a);
      int         base;
      int         off;
      logic [7:0] b;
      logic [15:0] h;
      base = int'(a[5:2]) * 4;
      off  = int'(a[1:0]);
      b    = model[base + off];
      h    = 16'h0;   // Offset 3 half stays zero
      if (off < 3) begin
         h = {model[base + off + 1], model[base + off]};
      end
      case (op)
         MEM_LB:  return {{24{b[7]}}, b};
         MEM_LBU: return {24'h0, b};
         MEM_LH:  return {{16{h[15]}}, h};
         MEM_LHU: return {16'h0, h};
         MEM_LW:  return {model[base + 3], model[base + 2], model[base + 1], model[base]};
         default: return 32'h0;
      endcase
   endfunction

   function automatic void applyStore(AccessSample s);
      int base;
      int off;
      base = int'(s.addr[5:2]) * 4;
      off  = int'(s.addr[1:0]);
      case (s.op)
         MEM_SB: model[base + off] = s.data[7:0];
         MEM_SH: begin
            if (off < 3) begin   // Word crossing half is dropped
               // Lane i of the replicated half holds half byte i mod 2
               for (int i = off; i <= off + 1; i++) begin
                  model[base + i] = s.data[8*(i % 2) +: 8];
               end
            end
         end
         MEM_SW: begin
            if (off == 0) begin
               for (int i = 0; i < 4; i++) begin
                  model[base + i] = s.data[8*i +: 8];
               end
            end
         end
         default: ;
      endcase
   endfunction

   task automatic reportMismatch(string name, logic [31:0] expVal, logic [31:0] gotVal);
      $display("Error t=%0t %s expected %h got %h", $time, name, expVal, gotVal);
      errCount++;
   endtask

   // Inputs settle after the rising edge, so the falling edge sees stable values
   always @(negedge clk) begin
      AccessSample cur;
      logic        expDone;
      logic        expBusy;
      logic [31:0] expData;
      cur.valid = 1'b1;
      cur.rstN  = rstN;
      cur.op    = instType;
      cur.addr  = addr;
      cur.data  = storeData;
      cur.exc   = exception;

      if (prev.valid) begin
         // The edge just passed consumed the previous sample
         if (isStore(prev.op) && !prev.exc) begin
            applyStore(prev);
         end
         expDone = prev.rstN && (isLoad(prev.op) || (isStore(prev.op) && !prev.exc));
         if (loadResult.done !== expDone) begin
            reportMismatch("loadResult.done", 32'(expDone), 32'(loadResult.done));
         end
         // Second cycle of a held load
         if (prev.rstN && isLoad(cur.op) && cur.op == prev.op && cur.addr == prev.addr) begin
            expData = expectedLoad(cur.op, cur.addr);
            loadCount++;
            if (loadResult.data !== expData) begin
               reportMismatch("loadResult.data", expData, loadResult.data);
            end
         end
      end

      expBusy = isLoad(cur.op) || (isStore(cur.op) && !cur.exc);   // Trapped store is no access
      if (busy !== expBusy) begin
         reportMismatch("busy", 32'(expBusy), 32'(busy));
      end
      prev = cur;
   end

endmodule

`default_nettype wire

// File: tb/MemStageTb.sv
`timescale 1ns/10ps
`default_nettype none

module MemStageTb;

   import Common::*;

   localparam logic [31:0] SEED = 32'h6c91_f78e;
   localparam int RESET_CYCLES   = 16;
   localparam int INIT_WORDS     = 16;
   localparam int RANDOM_OPS     = 400;
   localparam int CYCLES_PER_OP  = 3;   // Two held cycles and one idle
   localparam int TIMEOUT_CYCLES =
      RESET_CYCLES + CYCLES_PER_OP * (INIT_WORDS + RANDOM_OPS) + 200;

   logic                  clk;
   logic                  rstN;
   logic [ADDR_WIDTH-1:0] addr;
   memInstType            instType;
   logic [DATA_WIDTH-1:0] storeData;
   logic                  exception;
   MemResult              loadResult;
   logic                  busy;

   int          errorCount;
   int          loadChecks;
   int          cycleCount = 0;
   logic [31:0] rngState;

   ClockGen uClock (
      .clk  (clk),
      .rstN (rstN)
   );

   MemStage DUT (
      .clk        (clk),
      .rstN       (rstN),
      .addr       (addr),
      .instType   (instType),
      .storeData  (storeData),
      .exception  (exception),
      .loadResult (loadResult),
      .busy       (busy)
   );

   MemStageChecker uChecker (
      .clk        (clk),
      .rstN       (rstN),
      .addr       (addr),
      .instType   (instType),
      .storeData  (storeData),
      .exception  (exception),
      .loadResult (loadResult),
      .busy       (busy),
      .errorCount (errorCount),
      .loadChecks (loadChecks)
   );

   function automatic logic [31:0] xorshift(logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Present one access for two cycles, then one idle cycle
   task automatic applyOp(memInstType op, logic [ADDR_WIDTH-1:0] a,
                          logic [DATA_WIDTH-1:0] d, logic exc);
      @(posedge clk);
      instType  <= op;
      addr      <= a;
      storeData <= d;
      exception <= exc;
      repeat (2) @(posedge clk);
      instType  <= MEM_NONE;
      exception <= 1'b0;
   endtask

   always @(posedge clk) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= TIMEOUT_CYCLES) begin
         $display("Timeout: stimulus did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("TEST RESULT: FAIL");
         $finish;
      end
   end

   initial begin
      logic [31:0] r;
      memInstType  op;
      instType  = MEM_NONE;
      addr      = '0;
      storeData = '0;
      exception = 1'b0;
      rngState  = SEED;

      wait (rstN === 1'b1);

      // Known contents for every word the loads can reach
      for (int w = 0; w < INIT_WORDS; w++) begin
         rngState = xorshift(rngState);
         applyOp(MEM_SW, ADDR_WIDTH'(w * 4), rngState, 1'b0);
      end

      for (int n = 0; n < RANDOM_OPS; n++) begin
         rngState = xorshift(rngState);
         r        = rngState;
         op       = memInstType'(4'(r[2:0]) + 4'd1);   // MEM_LB up to MEM_SW
         rngState = xorshift(rngState);
         applyOp(op, ADDR_WIDTH'(r[8:3]), rngState, r[11:9] == 3'd0);
      end

      repeat (2) @(posedge clk);
      if (loadChecks == 0) begin
         $display("No load result was compared against the model");
      end
      $display("Closing counts: %0d errors, %0d load checks", errorCount, loadChecks);
      if (errorCount == 0 && loadChecks > 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: MemStage.f
src/Common.sv
src/ControllerMem.sv
src/StoreAligner.sv
src/DataMemory.sv
src/MemStage.sv
tb/ClockGen.sv
tb/MemStageChecker.sv
tb/MemStageTb.sv

// File: Bender.yml
package:
  name: mem_stage

sources:
  - src/Common.sv
  - src/ControllerMem.sv
  - src/StoreAligner.sv
  - src/DataMemory.sv
  - src/MemStage.sv
  - target: test
    files:
      - tb/ClockGen.sv
      - tb/MemStageChecker.sv
      - tb/MemStageTb.sv
